/* uart_pkg.sv */
package uart_pkg;

	// Data bits in one 8N1 frame.
	localparam int UART_DATA_BITS = 8;

	typedef logic [UART_DATA_BITS-1:0] uart_byte_t;

	// One receive FIFO entry.
	// The frame error flag lands in bit 8 when read over the bus.
	typedef struct packed {
		logic       frame_err;
		uart_byte_t data;
	} rx_entry_t;

	// Status register bit positions.
	// Receive FIFO holds at least one entry.
	localparam int STATUS_RX_AVAIL = 0;

	// Transmit FIFO cannot take another byte.
	localparam int STATUS_TX_FULL = 1;

	// Nothing queued and no frame on the line.
	localparam int STATUS_TX_IDLE = 2;

	// A frame arrived while the receive FIFO was full.
	localparam int STATUS_OVERRUN = 3;

endpackage

/* axi_lite_pkg.sv */
package axi_lite_pkg;

	// Bus widths.
	localparam int AXI_ADDR_W = 4;
	localparam int AXI_DATA_W = 32;

	// Response codes on B and R.
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Register map, byte offsets.
	// Offset 0xC and unaligned addresses are unmapped.
	localparam logic [AXI_ADDR_W-1:0] REG_RX_DATA = 4'h0;
	localparam logic [AXI_ADDR_W-1:0] REG_TX_DATA = 4'h4;
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 4'h8;

endpackage

/* sync_fifo.sv */
module sync_fifo #(
	parameter int DEPTH = 4,
	parameter type payload_t = logic [7:0]
) (
	input  logic     i_clock,
	input  logic     i_reset,
	input  logic     i_push,
	input  payload_t i_data,
	input  logic     i_pop,
	output payload_t o_data,
	output logic     o_full,
	output logic     o_empty
);
	localparam int ADDR_W = $clog2(DEPTH);

	payload_t mem [DEPTH];
	logic [ADDR_W:0] wr_ptr;
	logic [ADDR_W:0] rd_ptr;
	logic do_push;
	logic do_pop;

	// Extra pointer bit tells full from empty.
	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
		(wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && !o_empty;

	// Head entry shows while not empty.
	assign o_data = mem[rd_ptr[ADDR_W-1:0]];

	always_ff @(posedge i_clock) begin
		if (do_push) begin
			mem[wr_ptr[ADDR_W-1:0]] <= i_data;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

/* uart_receiver.sv */
module uart_receiver import uart_pkg::*; #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic      i_clock,
	input  logic      i_reset,
	input  logic      i_uart_rx,
	output logic      o_rx_valid,
	output rx_entry_t o_rx_entry
);
	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam int IDX_W = $clog2(UART_DATA_BITS);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;
	logic rx_q;
	logic bit_tick;
	logic [CNT_W-1:0] baud_cnt;
	logic [IDX_W-1:0] bit_idx;
	uart_byte_t shift_reg;

	assign bit_tick = (baud_cnt == '0);

	// One register stage on the line, idle high.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rx_q <= 1'b1;
		end else begin
			rx_q <= i_uart_rx;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= RX_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			o_rx_valid <= 1'b0;
		end else begin
			o_rx_valid <= 1'b0;
			if (state != RX_IDLE && !bit_tick) begin
				baud_cnt <= baud_cnt - 1'b1;
			end else begin
				case (state)
					RX_IDLE: begin
						// Falling edge, wait half a bit.
						if (!rx_q) begin
							state <= RX_START;
							baud_cnt <= CNT_W'(CLKS_PER_BIT / 2 - 1);
						end
					end
					RX_START: begin
						// Line back high at mid start bit is a glitch.
						if (!rx_q) begin
							state <= RX_DATA;
							baud_cnt <= CNT_W'(CLKS_PER_BIT - 1);
							bit_idx <= '0;
						end else begin
							state <= RX_IDLE;
						end
					end
					RX_DATA: begin
						baud_cnt <= CNT_W'(CLKS_PER_BIT - 1);
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == IDX_W'(UART_DATA_BITS - 1)) begin
							state <= RX_STOP;
						end
					end
					default: begin
						// Stop sample taken, deliver even on a bad stop bit.
						state <= RX_IDLE;
						o_rx_valid <= 1'b1;
					end
				endcase
			end
		end
	end

	// Data bits arrive LSB first.
	always_ff @(posedge i_clock) begin
		if (state == RX_DATA && bit_tick) begin
			shift_reg <= {rx_q, shift_reg[UART_DATA_BITS-1:1]};
		end
		if (state == RX_STOP && bit_tick) begin
			o_rx_entry.frame_err <= !rx_q;
			o_rx_entry.data <= shift_reg;
		end
	end

endmodule

/* uart_transmitter.sv */
module uart_transmitter import uart_pkg::*; #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic       i_clock,
	input  logic       i_reset,
	input  logic       i_fifo_empty,
	input  uart_byte_t i_fifo_data,
	output logic       o_fifo_pop,
	output logic       o_uart_tx,
	output logic       o_idle
);
	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	logic busy;
	logic tx_line;
	logic bit_tick;
	logic [CNT_W-1:0] baud_cnt;
	logic [3:0] bits_left;
	// Data bits followed by the stop bit.
	logic [UART_DATA_BITS:0] shift_reg;

	assign bit_tick = (baud_cnt == '0);
	assign o_fifo_pop = !busy && !i_fifo_empty;
	assign o_idle = !busy;
	assign o_uart_tx = tx_line;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			tx_line <= 1'b1;
			baud_cnt <= '0;
			bits_left <= '0;
		end else if (o_fifo_pop) begin
			// Start bit goes out as the byte leaves the FIFO.
			busy <= 1'b1;
			tx_line <= 1'b0;
			baud_cnt <= CNT_W'(CLKS_PER_BIT - 1);
			bits_left <= 4'(UART_DATA_BITS + 1);
		end else if (busy) begin
			if (!bit_tick) begin
				baud_cnt <= baud_cnt - 1'b1;
			end else if (bits_left == '0) begin
				// End of the stop bit.
				busy <= 1'b0;
			end else begin
				tx_line <= shift_reg[0];
				bits_left <= bits_left - 1'b1;
				baud_cnt <= CNT_W'(CLKS_PER_BIT - 1);
			end
		end
	end

	// Ones shift in behind, so the line rests high after the stop bit.
	always_ff @(posedge i_clock) begin
		if (o_fifo_pop) begin
			shift_reg <= {1'b1, i_fifo_data};
		end else if (busy && bit_tick) begin
			shift_reg <= {1'b1, shift_reg[UART_DATA_BITS:1]};
		end
	end

endmodule

/* uart_axi_regs.sv */
module uart_axi_regs import uart_pkg::*, axi_lite_pkg::*; (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_awvalid,
	output logic                    o_awready,
	input  logic [AXI_ADDR_W-1:0]   i_awaddr,
	input  logic                    i_wvalid,
	output logic                    o_wready,
	input  logic [AXI_DATA_W-1:0]   i_wdata,
	input  logic [AXI_DATA_W/8-1:0] i_wstrb,
	output logic                    o_bvalid,
	input  logic                    i_bready,
	output logic [1:0]              o_bresp,
	input  logic                    i_arvalid,
	output logic                    o_arready,
	input  logic [AXI_ADDR_W-1:0]   i_araddr,
	output logic                    o_rvalid,
	input  logic                    i_rready,
	output logic [AXI_DATA_W-1:0]   o_rdata,
	output logic [1:0]              o_rresp,
	input  rx_entry_t               i_rx_entry,
	input  logic                    i_rx_empty,
	output logic                    o_rx_pop,
	input  logic                    i_rx_valid,
	input  logic                    i_rx_full,
	output logic                    o_tx_push,
	output uart_byte_t              o_tx_data,
	input  logic                    i_tx_full,
	input  logic                    i_tx_idle,
	input  logic                    i_tx_empty
);
	logic wr_accept;
	logic wr_tx_hit;
	logic rd_accept;
	logic status_read;
	logic overrun;
	logic [AXI_DATA_W-1:0] status_word;
	logic [AXI_DATA_W-1:0] rd_data;
	logic [1:0] rd_resp;

	// Write channel, AW and W taken together.
	assign wr_accept = i_awvalid && i_wvalid && !o_bvalid;
	assign o_awready = wr_accept;
	assign o_wready = wr_accept;

	// The byte rides in lane 0, a write without it is rejected.
	assign wr_tx_hit = (i_awaddr == REG_TX_DATA) && i_wstrb[0];
	assign o_tx_push = wr_accept && wr_tx_hit && !i_tx_full;
	assign o_tx_data = i_wdata[UART_DATA_BITS-1:0];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_bvalid <= 1'b0;
		end else if (wr_accept) begin
			o_bvalid <= 1'b1;
		end else if (i_bready) begin
			o_bvalid <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (wr_accept) begin
			o_bresp <= (wr_tx_hit && !i_tx_full) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// Read channel.
	assign o_arready = !o_rvalid;
	assign rd_accept = i_arvalid && o_arready;
	assign status_read = rd_accept && (i_araddr == REG_STATUS);
	assign o_rx_pop = rd_accept && (i_araddr == REG_RX_DATA) && !i_rx_empty;

	always_comb begin
		status_word = '0;
		status_word[STATUS_RX_AVAIL] = !i_rx_empty;
		status_word[STATUS_TX_FULL] = i_tx_full;
		status_word[STATUS_TX_IDLE] = i_tx_empty && i_tx_idle;
		status_word[STATUS_OVERRUN] = overrun;
	end

	always_comb begin
		rd_data = '0;
		rd_resp = RESP_OKAY;
		case (i_araddr)
			REG_RX_DATA: begin
				// Empty FIFO reads as zero.
				if (!i_rx_empty) begin
					rd_data[$bits(rx_entry_t)-1:0] = i_rx_entry;
				end
			end
			REG_STATUS: begin
				rd_data = status_word;
			end
			default: begin
				rd_resp = RESP_SLVERR;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_rvalid <= 1'b0;
		end else if (rd_accept) begin
			o_rvalid <= 1'b1;
		end else if (i_rready) begin
			o_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (rd_accept) begin
			o_rdata <= rd_data;
			o_rresp <= rd_resp;
		end
	end

	// Sticky overrun, a new loss wins over the clear on read.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			overrun <= 1'b0;
		end else if (i_rx_valid && i_rx_full) begin
			overrun <= 1'b1;
		end else if (status_read) begin
			overrun <= 1'b0;
		end
	end

endmodule

/* uart_peripheral.sv */
module uart_peripheral import uart_pkg::*, axi_lite_pkg::*; #(
	parameter int CLKS_PER_BIT = 8,
	parameter int RX_FIFO_DEPTH = 4,
	parameter int TX_FIFO_DEPTH = 4
) (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_awvalid,
	output logic                    o_awready,
	input  logic [AXI_ADDR_W-1:0]   i_awaddr,
	input  logic                    i_wvalid,
	output logic                    o_wready,
	input  logic [AXI_DATA_W-1:0]   i_wdata,
	input  logic [AXI_DATA_W/8-1:0] i_wstrb,
	output logic                    o_bvalid,
	input  logic                    i_bready,
	output logic [1:0]              o_bresp,
	input  logic                    i_arvalid,
	output logic                    o_arready,
	input  logic [AXI_ADDR_W-1:0]   i_araddr,
	output logic                    o_rvalid,
	input  logic                    i_rready,
	output logic [AXI_DATA_W-1:0]   o_rdata,
	output logic [1:0]              o_rresp,
	input  logic                    i_uart_rx,
	output logic                    o_uart_tx
);
	// Receive side.
	logic rx_valid;
	rx_entry_t rx_entry;
	rx_entry_t rx_head;
	logic rx_pop;
	logic rx_full;
	logic rx_empty;

	// Transmit side.
	logic tx_push;
	uart_byte_t tx_data;
	uart_byte_t tx_head;
	logic tx_pop;
	logic tx_full;
	logic tx_empty;
	logic tx_idle;

	uart_axi_regs u_regs (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
		.i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata), .i_wstrb(i_wstrb),
		.o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
		.i_arvalid(i_arvalid), .o_arready(o_arready), .i_araddr(i_araddr),
		.o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp),
		.i_rx_entry(rx_head), .i_rx_empty(rx_empty), .o_rx_pop(rx_pop),
		.i_rx_valid(rx_valid), .i_rx_full(rx_full),
		.o_tx_push(tx_push), .o_tx_data(tx_data), .i_tx_full(tx_full),
		.i_tx_idle(tx_idle), .i_tx_empty(tx_empty)
	);

	sync_fifo #(
		.DEPTH(RX_FIFO_DEPTH),
		.payload_t(rx_entry_t)
	) u_rx_fifo (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_push(rx_valid), .i_data(rx_entry),
		.i_pop(rx_pop), .o_data(rx_head),
		.o_full(rx_full), .o_empty(rx_empty)
	);

	sync_fifo #(
		.DEPTH(TX_FIFO_DEPTH),
		.payload_t(uart_byte_t)
	) u_tx_fifo (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_push(tx_push), .i_data(tx_data),
		.i_pop(tx_pop), .o_data(tx_head),
		.o_full(tx_full), .o_empty(tx_empty)
	);

	uart_receiver #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_receiver (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_uart_rx(i_uart_rx),
		.o_rx_valid(rx_valid), .o_rx_entry(rx_entry)
	);

	uart_transmitter #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_transmitter (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_fifo_empty(tx_empty), .i_fifo_data(tx_head), .o_fifo_pop(tx_pop),
		.o_uart_tx(o_uart_tx), .o_idle(tx_idle)
	);

endmodule

/* uart_peripheral_assertions.sv */
module uart_peripheral_assertions import axi_lite_pkg::*; (
	input logic                  i_clock,
	input logic                  i_reset,
	input logic                  i_bvalid,
	input logic                  i_bready,
	input logic [1:0]            i_bresp,
	input logic                  i_rvalid,
	input logic                  i_rready,
	input logic [AXI_DATA_W-1:0] i_rdata,
	input logic [1:0]            i_rresp,
	input logic                  i_idle,
	input logic                  i_uart_tx
);
	timeunit 1ns;
	timeprecision 100ps;

	// A response holds until the master takes it.
	b_held: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_bvalid && !i_bready) |=> (i_bvalid && $stable(i_bresp)))
		else $error("Write response dropped or changed before it was accepted");

	r_held: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_rvalid && !i_rready) |=> (i_rvalid && $stable(i_rdata) && $stable(i_rresp)))
		else $error("Read response dropped or changed before it was accepted");

	// Line rests high between frames.
	line_idle: assert property (@(posedge i_clock) disable iff (i_reset)
		i_idle |-> i_uart_tx)
		else $error("Transmit line low while the transmitter is idle");

endmodule

// Serial ports tied quiet here.
bind uart_axi_regs uart_peripheral_assertions u_axi_assertions (
	.i_clock(i_clock), .i_reset(i_reset),
	.i_bvalid(o_bvalid), .i_bready(i_bready), .i_bresp(o_bresp),
	.i_rvalid(o_rvalid), .i_rready(i_rready), .i_rdata(o_rdata), .i_rresp(o_rresp),
	.i_idle(1'b0), .i_uart_tx(1'b1)
);

// Only the serial line is watched in this one.
bind uart_transmitter uart_peripheral_assertions u_tx_assertions (
	.i_clock(i_clock), .i_reset(i_reset),
	.i_bvalid(1'b0), .i_bready(1'b1), .i_bresp(2'b00),
	.i_rvalid(1'b0), .i_rready(1'b1), .i_rdata(32'h0), .i_rresp(2'b00),
	.i_idle(o_idle), .i_uart_tx(o_uart_tx)
);

/* uart_peripheral_tb.sv */
module uart_peripheral_tb import uart_pkg::*, axi_lite_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLKS_PER_BIT = 8;
	localparam int RX_FIFO_DEPTH = 4;
	localparam int TX_FIFO_DEPTH = 4;
	localparam int FRAME_CLKS = 10 * CLKS_PER_BIT;
	localparam logic [AXI_DATA_W-1:0] RX_AVAIL = 32'h1 << STATUS_RX_AVAIL;
	localparam logic [AXI_DATA_W-1:0] TX_FULL = 32'h1 << STATUS_TX_FULL;
	localparam logic [AXI_DATA_W-1:0] TX_IDLE = 32'h1 << STATUS_TX_IDLE;
	localparam logic [AXI_DATA_W-1:0] OVERRUN = 32'h1 << STATUS_OVERRUN;
	localparam logic [AXI_DATA_W-1:0] ALL_BITS = '1;
	localparam logic [AXI_DATA_W-1:0] ENTRY_BITS = 32'h1ff;

	typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_POLL, OP_INJECT, OP_LOOP} op_t;

	// Inject rows carry the stop level in data bit 8.
	typedef struct packed {
		op_t                   op;
		logic [AXI_ADDR_W-1:0] addr;
		logic [AXI_DATA_W-1:0] data;
		logic [1:0]            resp;
		logic [AXI_DATA_W-1:0] mask;
		logic [AXI_DATA_W-1:0] exp_data;
	} step_t;

	logic clock;
	logic reset;
	logic awvalid;
	logic awready;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic rready;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic [AXI_ADDR_W-1:0] araddr;
	logic [AXI_DATA_W-1:0] wdata;
	logic [AXI_DATA_W-1:0] rdata;
	logic [AXI_DATA_W/8-1:0] wstrb;
	logic [1:0] bresp;
	logic [1:0] rresp;
	logic uart_rx;
	logic uart_tx;
	logic loopback;
	logic inject_line;
	integer seed;
	int cycle_count;
	int cycle_limit;
	int tx_frames;
	int okay_writes;
	step_t steps[$];

	// Serial input comes from the transmitter or from the injector.
	assign uart_rx = loopback ? uart_tx : inject_line;

	uart_peripheral #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.RX_FIFO_DEPTH(RX_FIFO_DEPTH),
		.TX_FIFO_DEPTH(TX_FIFO_DEPTH)
	) u_dut (
		.i_clock(clock), .i_reset(reset),
		.i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
		.i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
		.o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
		.i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
		.o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp),
		.i_uart_rx(uart_rx), .o_uart_tx(uart_tx)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(input int row, input string name, input logic [31:0] got,
			input logic [31:0] want);
		assert (got == want) else begin
			fail_run($sformatf("ERR %s row %0d: got 0x%h expected 0x%h", name, row, got, want));
		end
	endtask

	// Responses come exactly one cycle after the handshake.
	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clock);
		awvalid <= 1'b1;
		awaddr <= addr;
		wvalid <= 1'b1;
		wdata <= data;
		wstrb <= 4'hf;
		bready <= 1'b1;
		do @(negedge clock); while (!(awready && wready));
		@(posedge clock);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		@(negedge clock);
		assert (bvalid) else begin
			fail_run($sformatf("ERR o_bvalid: got 0x%h expected 0x1", bvalid));
		end
		resp = bresp;
		@(posedge clock);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clock);
		arvalid <= 1'b1;
		araddr <= addr;
		rready <= 1'b1;
		do @(negedge clock); while (!arready);
		@(posedge clock);
		arvalid <= 1'b0;
		@(negedge clock);
		assert (rvalid) else begin
			fail_run($sformatf("ERR o_rvalid: got 0x%h expected 0x1", rvalid));
		end
		data = rdata;
		resp = rresp;
		@(posedge clock);
		rready <= 1'b0;
	endtask

	// Start bit, eight data bits LSB first, then the chosen stop level.
	task automatic inject_frame(input logic [7:0] value, input logic stop_level);
		logic [9:0] frame;
		frame = {stop_level, value, 1'b0};
		@(posedge clock);
		for (int i = 0; i < 10; i++) begin
			inject_line <= frame[i];
			repeat (CLKS_PER_BIT) @(posedge clock);
		end
		inject_line <= 1'b1;
	endtask

	task automatic add_step(input op_t op, input logic [3:0] addr, input logic [31:0] data,
			input logic [1:0] resp, input logic [31:0] mask, input logic [31:0] exp_data);
		steps.push_back('{op, addr, data, resp, mask, exp_data});
	endtask

	task automatic build_table();
		logic [7:0] value [6];
		add_step(OP_READ, REG_STATUS, 0, RESP_OKAY, ALL_BITS, TX_IDLE);
		add_step(OP_READ, REG_RX_DATA, 0, RESP_OKAY, ALL_BITS, 0);
		// Loopback of three bytes.
		for (int k = 0; k < 3; k++) begin
			value[k] = 8'($random(seed));
			add_step(OP_WRITE, REG_TX_DATA, 32'(value[k]), RESP_OKAY, 0, 0);
		end
		add_step(OP_POLL, REG_STATUS, 0, RESP_OKAY, TX_IDLE | RX_AVAIL, TX_IDLE | RX_AVAIL);
		for (int k = 0; k < 3; k++) begin
			add_step(OP_READ, REG_RX_DATA, 0, RESP_OKAY, ENTRY_BITS, 32'(value[k]));
		end
		add_step(OP_READ, REG_STATUS, 0, RESP_OKAY, RX_AVAIL, 0);
		// Framing error, flag lands in bit 8.
		add_step(OP_LOOP, 0, 0, RESP_OKAY, 0, 0);
		value[0] = 8'($random(seed));
		add_step(OP_INJECT, 0, 32'({1'b0, value[0]}), RESP_OKAY, 0, 0);
		add_step(OP_POLL, REG_STATUS, 0, RESP_OKAY, RX_AVAIL, RX_AVAIL);
		add_step(OP_READ, REG_RX_DATA, 0, RESP_OKAY, ENTRY_BITS, 32'({1'b1, value[0]}));
		// Five frames into a four-deep FIFO.
		for (int k = 0; k < 5; k++) begin
			value[k] = 8'($random(seed));
			add_step(OP_INJECT, 0, 32'({1'b1, value[k]}), RESP_OKAY, 0, 0);
		end
		add_step(OP_READ, REG_STATUS, 0, RESP_OKAY, OVERRUN, OVERRUN);
		add_step(OP_READ, REG_STATUS, 0, RESP_OKAY, OVERRUN, 0);
		for (int k = 0; k < RX_FIFO_DEPTH; k++) begin
			add_step(OP_READ, REG_RX_DATA, 0, RESP_OKAY, ENTRY_BITS, 32'(value[k]));
		end
		add_step(OP_READ, REG_STATUS, 0, RESP_OKAY, RX_AVAIL, 0);
		// One frame in flight plus a full FIFO, the sixth write bounces.
		for (int k = 0; k < 6; k++) begin
			value[k] = 8'($random(seed));
			add_step(OP_WRITE, REG_TX_DATA, 32'(value[k]),
				(k < TX_FIFO_DEPTH + 1) ? RESP_OKAY : RESP_SLVERR, 0, 0);
		end
		add_step(OP_READ, REG_STATUS, 0, RESP_OKAY, TX_FULL, TX_FULL);
		add_step(OP_POLL, REG_STATUS, 0, RESP_OKAY, TX_IDLE, TX_IDLE);
		add_step(OP_READ, 4'hc, 0, RESP_SLVERR, ALL_BITS, 0);
		add_step(OP_WRITE, 4'hc, 32'h5a, RESP_SLVERR, 0, 0);
	endtask

	task automatic run_step(input int row, input step_t s);
		logic [1:0] resp;
		logic [31:0] data;
		case (s.op)
			OP_WRITE: begin
				axi_write(s.addr, s.data, resp);
				check_value(row, "o_bresp", 32'(resp), 32'(s.resp));
				if (resp == RESP_OKAY && s.addr == REG_TX_DATA) begin
					okay_writes++;
				end
			end
			OP_READ: begin
				axi_read(s.addr, data, resp);
				check_value(row, "o_rresp", 32'(resp), 32'(s.resp));
				check_value(row, "o_rdata", data & s.mask, s.exp_data);
			end
			OP_POLL: begin
				do begin
					axi_read(s.addr, data, resp);
				end while ((data & s.mask) != s.exp_data);
				check_value(row, "o_rresp", 32'(resp), 32'(s.resp));
			end
			OP_INJECT: begin
				inject_frame(s.data[7:0], s.data[8]);
			end
			default: begin
				@(posedge clock);
				loopback <= s.data[0];
			end
		endcase
	endtask

	// Counts frames on the transmit line and checks their stop bits.
	initial begin
		tx_frames = 0;
		forever begin
			@(negedge uart_tx);
			repeat (FRAME_CLKS - CLKS_PER_BIT / 2) @(posedge clock);
			assert (uart_tx) else begin
				fail_run($sformatf("ERR o_uart_tx stop bit: got 0x%h expected 0x1", uart_tx));
			end
			tx_frames++;
		end
	end

	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clock);
			cycle_count++;
			if (cycle_count >= cycle_limit) begin
				fail_run($sformatf("Timeout: the run did not end within %0d cycles", cycle_limit));
			end
		end
	end

	initial begin
		reset <= 1'b1;
		awvalid <= 1'b0;
		awaddr <= '0;
		wvalid <= 1'b0;
		wdata <= '0;
		wstrb <= '0;
		bready <= 1'b0;
		arvalid <= 1'b0;
		araddr <= '0;
		rready <= 1'b0;
		loopback <= 1'b1;
		inject_line <= 1'b1;
		okay_writes = 0;
		seed = 32'ha7709fb7;
		build_table();
		// Worst row is a full transmit FIFO draining.
		cycle_limit = steps.size() * FRAME_CLKS * TX_FIFO_DEPTH + 1000;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		foreach (steps[i]) begin
			run_step(i, steps[i]);
		end
		assert (tx_frames == okay_writes) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			fail_run($sformatf("ERR tx frame count: got 0x%h expected 0x%h",
				tx_frames, okay_writes));
		end
	end

endmodule

/* uart_peripheral.f */
uart_pkg.sv
axi_lite_pkg.sv
sync_fifo.sv
uart_receiver.sv
uart_transmitter.sv
uart_axi_regs.sv
uart_peripheral.sv
uart_peripheral_assertions.sv
uart_peripheral_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/100ps --top-module uart_peripheral_tb \
	-f uart_peripheral.f
status=0
output=$(./obj_dir/Vuart_peripheral_tb) || status=$?
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -q "PASS: all tests"; then
	exit 0
fi
echo "simulation ended with status $status"
exit 1
